// ==== conv_config.svh ====
`ifndef CONV_CONFIG_SVH
`define CONV_CONFIG_SVH

// frame geometry
`define CONV_IMG_W 12
`define CONV_IMG_H 8

// one filter per lane
`define CONV_NUM_LANES 4

// 3x3 window
`define CONV_TAPS 9

// data widths
`define CONV_PIX_W 8
`define CONV_ACC_W 20

// M0 width, also the load data width
`define CONV_M0_W 32

`endif

// ==== conv_pkg.sv ====
`include "conv_config.svh"

package conv_pkg;

    typedef logic signed [`CONV_PIX_W-1:0] pixel_t;
    typedef logic signed [`CONV_PIX_W-1:0] weight_t;
    typedef logic signed [`CONV_ACC_W-1:0] acc_t;
    typedef logic signed [`CONV_M0_W-1:0]  param_t;
    typedef logic signed [`CONV_PIX_W-1:0] result_t;

    // row-major, entry 0 is top left
    typedef pixel_t [`CONV_TAPS-1:0] window_t;

    typedef logic [$clog2(`CONV_NUM_LANES)-1:0] lane_idx_t;

    // 0..8 select a tap weight
    typedef logic [3:0] wt_sel_t;

    localparam wt_sel_t SEL_M0   = 4'd9;
    localparam wt_sel_t SEL_ZP   = 4'd10;
    localparam wt_sel_t SEL_BIAS = 4'd11;

endpackage

// ==== line_window.sv ====
`timescale 1ns/100ps
`include "conv_config.svh"

module line_window (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              pix_valid,
    input  logic              pix_first,
    input  conv_pkg::pixel_t  pix_data,
    output logic              win_valid,
    output logic              win_last,
    output conv_pkg::window_t win_data
);
    import conv_pkg::*;

    localparam int COL_W = $clog2(`CONV_IMG_W);
    localparam int ROW_W = $clog2(`CONV_IMG_H);

    localparam logic [COL_W-1:0] LAST_COL = COL_W'(`CONV_IMG_W - 1);
    localparam logic [ROW_W-1:0] LAST_ROW = ROW_W'(`CONV_IMG_H - 1);

    logic [COL_W-1:0] col_cnt;
    logic [ROW_W-1:0] row_cnt;
    logic [COL_W-1:0] cur_col;
    logic [ROW_W-1:0] cur_row;
    logic             col_ok;
    logic             row_ok;

    // line_a holds the previous row, line_b the one before it
    pixel_t line_a [`CONV_IMG_W];
    pixel_t line_b [`CONV_IMG_W];
    pixel_t above1;
    pixel_t above2;

    //////////////////////////////
    // position tracking
    //////////////////////////////

    // first pixel restarts the frame at 0,0
    assign cur_col = pix_first ? '0 : col_cnt;
    assign cur_row = pix_first ? '0 : row_cnt;

    assign col_ok = (cur_col >= COL_W'(2));
    assign row_ok = (cur_row >= ROW_W'(2));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            col_cnt <= '0;
            row_cnt <= '0;
        end else if (pix_valid) begin
            if (cur_col == LAST_COL) begin
                col_cnt <= '0;
                if (cur_row == LAST_ROW) begin
                    row_cnt <= '0;
                end else begin
                    row_cnt <= cur_row + 1'b1;
                end
            end else begin
                col_cnt <= cur_col + 1'b1;
                row_cnt <= cur_row;
            end
        end
    end

    // no padding, only windows fully inside the frame
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            win_valid <= 1'b0;
            win_last  <= 1'b0;
        end else begin
            win_valid <= pix_valid && col_ok && row_ok;
            win_last  <= pix_valid && (cur_col == LAST_COL) && (cur_row == LAST_ROW);
        end
    end

    //////////////////////////////
    // line buffers and window
    //////////////////////////////

    assign above1 = line_a[cur_col];
    assign above2 = line_b[cur_col];

    always_ff @(posedge clk) begin
        if (pix_valid) begin
            line_a[cur_col] <= pix_data;
            line_b[cur_col] <= above1;
        end
    end

    // shift left by one column, new column enters on the right
    always_ff @(posedge clk) begin
        if (pix_valid) begin
            for (int r = 0; r < 3; r++) begin
                win_data[3*r]   <= win_data[3*r+1];
                win_data[3*r+1] <= win_data[3*r+2];
            end
            win_data[2] <= above2;
            win_data[5] <= above1;
            win_data[8] <= pix_data;
        end
    end

endmodule

// ==== filter_lane.sv ====
`timescale 1ns/100ps
`include "conv_config.svh"

module filter_lane #(
    parameter int LANE_ID = 0
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                win_valid,
    input  logic                win_last,
    input  conv_pkg::window_t   win_data,
    input  logic                load_valid,
    input  conv_pkg::lane_idx_t load_lane,
    input  conv_pkg::wt_sel_t   load_sel,
    input  conv_pkg::param_t    load_data,
    output logic                lane_valid,
    output logic                last_valid,
    output conv_pkg::result_t   lane_result
);
    import conv_pkg::*;

    weight_t wts [`CONV_TAPS];
    param_t  m0;
    param_t  zp;
    param_t  bias;

    acc_t    mac_sum;
    acc_t    acc_r;
    logic    mac_valid;
    logic    mac_last;

    logic signed [63:0] biased;
    logic signed [63:0] prod;
    logic signed [31:0] prod_hi;
    logic signed [33:0] rounded;
    result_t            sat;

    //////////////////////////////
    // coefficient store
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (load_valid && (load_lane == lane_idx_t'(LANE_ID))) begin
            case (load_sel)
                SEL_M0:   m0   <= load_data;
                SEL_ZP:   zp   <= load_data;
                SEL_BIAS: bias <= load_data;
                default: begin
                    if (load_sel < wt_sel_t'(`CONV_TAPS)) begin
                        wts[load_sel] <= weight_t'(load_data[`CONV_PIX_W-1:0]);
                    end
                end
            endcase
        end
    end

    //////////////////////////////
    // stage 1, 9-tap MAC
    //////////////////////////////

    always_comb begin
        mac_sum = '0;
        for (int k = 0; k < `CONV_TAPS; k++) begin
            pixel_t pix;
            pix     = win_data[k];
            mac_sum = mac_sum + (acc_t'(pix) * acc_t'(wts[k]));
        end
    end

    always_ff @(posedge clk) begin
        if (win_valid) begin
            acc_r <= mac_sum;
        end
    end

    //////////////////////////////
    // stage 2, requantize
    //////////////////////////////

    // upper word of M0 * (acc - zp + bias), rounded on bit 31
    always_comb begin
        biased  = 64'(acc_r) - 64'(zp) + 64'(bias);
        prod    = biased * 64'(m0);
        prod_hi = prod[63:32];
        rounded = 34'(prod_hi) + 34'(prod[31]) - 34'd128;
        if (rounded > 34'sd127) begin
            sat = 8'sd127;
        end else if (rounded < -34'sd128) begin
            sat = -8'sd128;
        end else begin
            sat = result_t'(rounded[`CONV_PIX_W-1:0]);
        end
    end

    always_ff @(posedge clk) begin
        if (mac_valid) begin
            lane_result <= sat;
        end
    end

    // valid and last travel alongside the data
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mac_valid  <= 1'b0;
            mac_last   <= 1'b0;
            lane_valid <= 1'b0;
            last_valid <= 1'b0;
        end else begin
            mac_valid  <= win_valid;
            mac_last   <= win_valid && win_last;
            lane_valid <= mac_valid;
            last_valid <= mac_last;
        end
    end

endmodule

// ==== result_drain.sv ====
`timescale 1ns/100ps
`include "conv_config.svh"

module result_drain (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                lane_valid,
    input  logic                last_valid,
    input  conv_pkg::result_t   lane_results [`CONV_NUM_LANES],
    output logic                out_valid,
    output logic                frame_done,
    output conv_pkg::result_t   out_data,
    output conv_pkg::lane_idx_t out_lane
);
    import conv_pkg::*;

    localparam lane_idx_t LAST_LANE = lane_idx_t'(`CONV_NUM_LANES - 1);

    result_t   shift_q [`CONV_NUM_LANES];
    lane_idx_t lane_cnt;
    logic      active;
    logic      grp_last;

    //////////////////////////////
    // group control
    //////////////////////////////

    // a new group overrides whatever is still draining
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            active   <= 1'b0;
            lane_cnt <= '0;
            grp_last <= 1'b0;
        end else if (lane_valid) begin
            active   <= 1'b1;
            lane_cnt <= '0;
            grp_last <= last_valid;
        end else if (active) begin
            lane_cnt <= lane_idx_t'(lane_cnt + 1'b1);
            if (lane_cnt == LAST_LANE) begin
                active <= 1'b0;
            end
        end
    end

    //////////////////////////////
    // result shift register
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (lane_valid) begin
            shift_q <= lane_results;
        end else if (active) begin
            for (int k = 0; k < `CONV_NUM_LANES - 1; k++) begin
                shift_q[k] <= shift_q[k+1];
            end
        end
    end

    assign out_valid = active;
    assign out_data  = shift_q[0];
    assign out_lane  = lane_cnt;

    // final lane of the frame's last window
    assign frame_done = active && grp_last && (lane_cnt == LAST_LANE);

endmodule

// ==== conv_layer_top.sv ====
`timescale 1ns/100ps
`include "conv_config.svh"

module conv_layer_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                pix_valid,
    input  logic                pix_first,
    input  conv_pkg::pixel_t    pix_data,
    input  logic                load_valid,
    input  conv_pkg::lane_idx_t load_lane,
    input  conv_pkg::wt_sel_t   load_sel,
    input  conv_pkg::param_t    load_data,
    output logic                out_valid,
    output conv_pkg::result_t   out_data,
    output conv_pkg::lane_idx_t out_lane,
    output logic                frame_done
);
    import conv_pkg::*;

    logic    win_valid;
    logic    win_last;
    window_t win_data;

    result_t lane_result    [`CONV_NUM_LANES];
    logic    lane_valid_vec [`CONV_NUM_LANES];
    logic    last_valid_vec [`CONV_NUM_LANES];

    line_window u_window (
        .clk       (clk),
        .rst_n     (rst_n),
        .pix_valid (pix_valid),
        .pix_first (pix_first),
        .pix_data  (pix_data),
        .win_valid (win_valid),
        .win_last  (win_last),
        .win_data  (win_data)
    );

    // one lane per filter, all on the same pipeline timing
    for (genvar i = 0; i < `CONV_NUM_LANES; i++) begin : g_lane
        filter_lane #(
            .LANE_ID (i)
        ) u_lane (
            .clk         (clk),
            .rst_n       (rst_n),
            .win_valid   (win_valid),
            .win_last    (win_last),
            .win_data    (win_data),
            .load_valid  (load_valid),
            .load_lane   (load_lane),
            .load_sel    (load_sel),
            .load_data   (load_data),
            .lane_valid  (lane_valid_vec[i]),
            .last_valid  (last_valid_vec[i]),
            .lane_result (lane_result[i])
        );
    end

    // lane 0 speaks for the whole group
    result_drain u_drain (
        .clk          (clk),
        .rst_n        (rst_n),
        .lane_valid   (lane_valid_vec[0]),
        .last_valid   (last_valid_vec[0]),
        .lane_results (lane_result),
        .out_valid    (out_valid),
        .frame_done   (frame_done),
        .out_data     (out_data),
        .out_lane     (out_lane)
    );

endmodule

// ==== tb_conv_layer.sv ====
`timescale 1ns/100ps
`include "conv_config.svh"

module tb_conv_layer;
    import conv_pkg::*;

    localparam int IMG_W         = `CONV_IMG_W;
    localparam int IMG_H         = `CONV_IMG_H;
    localparam int LANES         = `CONV_NUM_LANES;
    localparam int TAPS          = `CONV_TAPS;
    localparam int DRV           = 10;
    localparam int NUM_FRAMES    = 4;
    localparam int RELOAD_LANE   = 1;
    localparam int OUT_PER_FRAME = (IMG_W - 2) * (IMG_H - 2) * LANES;
    // abandoned frame stays inside rows 0 and 1
    localparam int PARTIAL_PIX   = IMG_W + 5;
    // two full loads, one single lane reload, reset
    localparam int SETUP_CYCLES  = 2 * LANES * (TAPS + 3) + (TAPS + 3) + 16;
    localparam int TIMEOUT       = NUM_FRAMES * IMG_W * IMG_H * (LANES + 1)
                                   + PARTIAL_PIX * (LANES + 1)
                                   + SETUP_CYCLES + 200;

    logic      clk;
    logic      rst_n;
    logic      pix_valid;
    logic      pix_first;
    pixel_t    pix_data;
    logic      load_valid;
    lane_idx_t load_lane;
    wt_sel_t   load_sel;
    param_t    load_data;
    logic      out_valid;
    result_t   out_data;
    lane_idx_t out_lane;
    logic      frame_done;

    integer seed      = 41067;
    int     cycle_cnt = 0;

    // reference model state
    int wt_m   [LANES][TAPS];
    int m0_m   [LANES];
    int zp_m   [LANES];
    int bias_m [LANES];
    int frame  [IMG_H][IMG_W];
    int got    [NUM_FRAMES][OUT_PER_FRAME];
    int exp_data_q [$];
    int exp_lane_q [$];
    int frame_out_cnt = 0;
    int done_cnt      = 0;
    bit sat_hi_seen   = 1'b0;
    bit sat_lo_seen   = 1'b0;

    conv_layer_top DUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .pix_valid  (pix_valid),
        .pix_first  (pix_first),
        .pix_data   (pix_data),
        .load_valid (load_valid),
        .load_lane  (load_lane),
        .load_sel   (load_sel),
        .load_data  (load_data),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .out_lane   (out_lane),
        .frame_done (frame_done)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Regression failed");
        $fatal(1);
    endtask

    //////////////////////////////
    // reference model
    //////////////////////////////

    function automatic int window_sum(input int row, input int col, input int lane);
        int sum;
        sum = 0;
        for (int r = 0; r < 3; r++) begin
            for (int c = 0; c < 3; c++) begin
                sum += frame[row-2+r][col-2+c] * wt_m[lane][3*r+c];
            end
        end
        return sum;
    endfunction

    // upper word of the 64 bit product, round on bit 31, offset and clamp
    function automatic int requant(input int acc, input int lane);
        longint q;
        longint r;
        q = longint'(m0_m[lane]) * (longint'(acc) - longint'(zp_m[lane])
            + longint'(bias_m[lane]));
        r = (q >>> 32) + longint'(q[31]) - 128;
        if (r > 127) begin
            r = 127;
        end else if (r < -128) begin
            r = -128;
        end
        return int'(r);
    endfunction

    task automatic build_expected();
        for (int r = 2; r < IMG_H; r++) begin
            for (int c = 2; c < IMG_W; c++) begin
                for (int l = 0; l < LANES; l++) begin
                    exp_data_q.push_back(requant(window_sum(r, c, l), l));
                    exp_lane_q.push_back(l);
                end
            end
        end
    endtask

    //////////////////////////////
    // stimulus
    //////////////////////////////

    task automatic load_word(input int lane, input int sel, input int data);
        @(posedge clk);
        #DRV;
        load_valid = 1'b1;
        load_lane  = lane_idx_t'(lane);
        load_sel   = wt_sel_t'(sel);
        load_data  = param_t'(data);
    endtask

    task automatic end_load();
        @(posedge clk);
        #DRV;
        load_valid = 1'b0;
    endtask

    // big selects large weights and a large M0
    task automatic load_lane_params(input int lane, input bit big);
        logic signed [7:0] w8;
        int w;
        for (int k = 0; k < TAPS; k++) begin
            if (big) begin
                w = 100 + ($unsigned($random(seed)) % 28);
                if ($random(seed) & 1) begin
                    w = -w;
                end
            end else begin
                w8 = $random(seed);
                w  = w8;
            end
            wt_m[lane][k] = w;
            load_word(lane, k, w);
        end
        if (big) begin
            m0_m[lane]   = 32'h4000_0000;
            zp_m[lane]   = 0;
            bias_m[lane] = 0;
        end else begin
            m0_m[lane]   = 32'h0100_0000 + ($unsigned($random(seed)) % 32'h0010_0000);
            zp_m[lane]   = $random(seed) % 256;
            bias_m[lane] = 32768 + ($random(seed) % 4096);
        end
        load_word(lane, int'(SEL_M0), m0_m[lane]);
        load_word(lane, int'(SEL_ZP), zp_m[lane]);
        load_word(lane, int'(SEL_BIAS), bias_m[lane]);
    endtask

    task automatic fill_frame();
        logic signed [7:0] p;
        for (int r = 0; r < IMG_H; r++) begin
            for (int c = 0; c < IMG_W; c++) begin
                p = $random(seed);
                frame[r][c] = p;
            end
        end
    endtask

    task automatic send_pixel(input int value, input bit first);
        @(posedge clk);
        #DRV;
        pix_valid = 1'b1;
        pix_first = first;
        pix_data  = pixel_t'(value);
        @(posedge clk);
        #DRV;
        pix_valid = 1'b0;
        pix_first = 1'b0;
        repeat (LANES - 1) @(posedge clk);
    endtask

    task automatic run_frame();
        int target;
        target = done_cnt + 1;
        build_expected();
        for (int r = 0; r < IMG_H; r++) begin
            for (int c = 0; c < IMG_W; c++) begin
                send_pixel(frame[r][c], (r == 0) && (c == 0));
            end
        end
        while (done_cnt < target) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);
    endtask

    //////////////////////////////
    // output monitor
    //////////////////////////////

    always @(negedge clk) begin
        int exp_data;
        int exp_lane;
        if (rst_n && out_valid) begin
            assert (exp_data_q.size() > 0) else begin
                report_failure($sformatf("output at %0t with no result pending", $time));
            end
            exp_data = exp_data_q.pop_front();
            exp_lane = exp_lane_q.pop_front();
            assert (int'(out_lane) == exp_lane) else begin
                report_failure($sformatf("mismatch at %0t: out_lane expected %0d got %0d",
                    $time, exp_lane, out_lane));
            end
            assert (int'(out_data) == exp_data) else begin
                report_failure($sformatf("mismatch at %0t: lane %0d expected %0d got %0d",
                    $time, exp_lane, exp_data, out_data));
            end
            got[done_cnt][frame_out_cnt] = int'(out_data);
            frame_out_cnt++;
            if (done_cnt == NUM_FRAMES - 1) begin
                if (out_data == 8'sd127) sat_hi_seen = 1'b1;
                if (out_data == -8'sd128) sat_lo_seen = 1'b1;
            end
            assert (frame_done == (frame_out_cnt == OUT_PER_FRAME)) else begin
                report_failure($sformatf("mismatch at %0t: frame_done %0b after %0d outputs",
                    $time, frame_done, frame_out_cnt));
            end
            if (frame_done) begin
                done_cnt++;
                frame_out_cnt = 0;
            end
        end else if (rst_n) begin
            assert (!frame_done) else begin
                report_failure($sformatf("mismatch at %0t: frame_done without an output",
                    $time));
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT) begin
            report_failure($sformatf("run timed out after %0d cycles", cycle_cnt));
        end
    end

    //////////////////////////////
    // test sequence
    //////////////////////////////

    initial begin
        int changed;
        rst_n      = 1'b0;
        pix_valid  = 1'b0;
        pix_first  = 1'b0;
        pix_data   = '0;
        load_valid = 1'b0;
        load_lane  = '0;
        load_sel   = '0;
        load_data  = '0;
        repeat (16) @(posedge clk);
        #DRV;
        rst_n = 1'b1;

        for (int l = 0; l < LANES; l++) begin
            load_lane_params(l, 1'b0);
        end
        end_load();
        fill_frame();
        run_frame();

        // abandoned frame, too short to reach a full window
        for (int i = 0; i < PARTIAL_PIX; i++) begin
            send_pixel($random(seed), i == 0);
        end

        // fresh data, restarted by pix_first
        fill_frame();
        run_frame();

        // same pixels again, only one lane gets new coefficients
        load_lane_params(RELOAD_LANE, 1'b0);
        end_load();
        run_frame();

        for (int l = 0; l < LANES; l++) begin
            load_lane_params(l, 1'b1);
        end
        end_load();
        fill_frame();
        run_frame();

        changed = 0;
        assert (exp_data_q.size() == 0) else begin
            report_failure($sformatf("%0d expected results never appeared",
                exp_data_q.size()));
        end
        assert (sat_hi_seen && sat_lo_seen) else begin
            report_failure("saturation frame did not reach both 127 and -128");
        end
        for (int i = 0; i < OUT_PER_FRAME; i++) begin
            if (i % LANES == RELOAD_LANE) begin
                if (got[2][i] != got[1][i]) changed++;
            end else begin
                assert (got[2][i] == got[1][i]) else begin
                    report_failure($sformatf(
                        "mismatch at %0t: output %0d of lane %0d changed after reload",
                        $time, i, i % LANES));
                end
            end
        end
        assert (changed > 0) else begin
            report_failure("reloaded lane produced the same results as before");
        end

        $display("Regression passed");
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+.
conv_pkg.sv
line_window.sv
filter_lane.sv
result_drain.sv
conv_layer_top.sv
tb_conv_layer.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = tb_conv_layer
FILELIST  = sim.f
BUILD_DIR = obj_dir
LOG       = sim.log

SOURCES = $(wildcard *.sv) $(wildcard *.svh)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

test: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
